// ==== hdl/l2_smi_pkg.sv ====
`default_nettype none

package l2_smi_pkg;

	// Line addresses count 64-byte lines, so the byte address is this value shifted by 6
	localparam int LINE_ADDR_WIDTH = 26;
	localparam int WORD_WIDTH = 32;
	localparam int LINE_WIDTH = 512;

	// One line moves as 16 beats of one word each
	localparam int BURST_BEATS = 16;
	localparam int BEAT_WIDTH = $clog2(BURST_BEATS);

	typedef logic [LINE_ADDR_WIDTH-1:0] line_addr_t;
	typedef logic [31:0] mem_addr_t;
	typedef logic [WORD_WIDTH-1:0] word_t;

	// Beat 0 sits in the most significant word
	typedef logic [LINE_WIDTH-1:0] line_t;

	typedef logic [1:0] way_t;

	// Unit in the upper two bits, strand in the lower two
	typedef logic [3:0] req_id_t;

	typedef enum logic [2:0]
	{
		PCI_LOAD = 3'd0,
		PCI_STORE = 3'd1,
		PCI_FLUSH = 3'd2,
		PCI_INVALIDATE = 3'd3
	} pci_op_t;

	typedef enum logic [1:0]
	{
		STATE_IDLE,
		STATE_WRITE,
		STATE_READ,
		STATE_ISSUE
	} smi_state_t;

endpackage

`default_nettype wire

// ==== hdl/l2_sync_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_sync_fifo
	#(
		parameter int WIDTH = 32,
		parameter int DEPTH = 12
	)
	(
		input wire clk,
		input wire arst_n_i,
		input wire enqueue_i,
		input wire [WIDTH-1:0] value_i,
		input wire dequeue_i,
		output logic full_o,
		output logic empty_o,
		output logic [WIDTH-1:0] value_o
	);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] storage [DEPTH];
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [COUNT_WIDTH-1:0] count;

	assign full_o = count == COUNT_WIDTH'(DEPTH);
	assign empty_o = count == '0;
	assign value_o = storage[rd_ptr];

	// DEPTH need not be a power of two, so the pointers wrap explicitly
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (enqueue_i)
				wr_ptr <= (wr_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

			if (dequeue_i)
				rd_ptr <= (rd_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

			if (enqueue_i && !dequeue_i)
				count <= count + 1'b1;
			else if (dequeue_i && !enqueue_i)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (enqueue_i)
			storage[wr_ptr] <= value_i;
	end

	assert property (@(posedge clk) disable iff (!arst_n_i) enqueue_i |-> !full_o);
	assert property (@(posedge clk) disable iff (!arst_n_i) dequeue_i |-> !empty_o);

endmodule

`default_nettype wire

// ==== hdl/l2_pending_miss.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_pending_miss import l2_smi_pkg::*;
	#(
		parameter int PENDING_ENTRIES = 4
	)
	(
		input wire clk,
		input wire arst_n_i,
		input wire lookup_valid_i,
		input wire line_addr_t lookup_addr_i,
		input wire alloc_i,
		input wire release_i,
		input wire line_addr_t release_addr_i,
		output logic duplicate_o
	);

	localparam int IDX_WIDTH = (PENDING_ENTRIES > 1) ? $clog2(PENDING_ENTRIES) : 1;

	logic [PENDING_ENTRIES-1:0] valid_q;
	line_addr_t addr_q [PENDING_ENTRIES];
	logic [PENDING_ENTRIES-1:0] hit_vec;
	logic [IDX_WIDTH-1:0] free_idx;

	always_comb
	begin
		for (int i = 0; i < PENDING_ENTRIES; i++)
			hit_vec[i] = valid_q[i] && addr_q[i] == lookup_addr_i;
	end

	assign duplicate_o = lookup_valid_i && |hit_vec;

	// Lowest free slot wins
	always_comb
	begin
		free_idx = '0;
		for (int i = PENDING_ENTRIES - 1; i >= 0; i--)
		begin
			if (!valid_q[i])
				free_idx = IDX_WIDTH'(i);
		end
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
			valid_q <= '0;
		else
		begin
			for (int i = 0; i < PENDING_ENTRIES; i++)
			begin
				if (release_i && valid_q[i] && addr_q[i] == release_addr_i)
					valid_q[i] <= 1'b0;
			end

			if (alloc_i)
				valid_q[free_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc_i)
			addr_q[free_idx] <= lookup_addr_i;
	end

	// More loads in flight than table entries would lose a duplicate match
	assert property (@(posedge clk) disable iff (!arst_n_i) alloc_i |-> !(&valid_q));

endmodule

`default_nettype wire

// ==== hdl/l2_smi_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_smi_queue import l2_smi_pkg::*;
	#(
		parameter int SET_INDEX_WIDTH = 8,
		parameter int QUEUE_DEPTH = 12,
		parameter int PENDING_ENTRIES = 4
	)
	(
		input wire clk,
		input wire arst_n_i,
		input wire rd_valid_i,
		input wire req_id_t rd_id_i,
		input wire pci_op_t rd_op_i,
		input wire way_t rd_way_i,
		input wire line_addr_t rd_addr_i,
		input wire rd_has_sm_data_i,
		input wire rd_hit_i,
		input wire way_t rd_replace_way_i,
		input wire [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] rd_old_tag_i,
		input wire rd_dirty_i,
		input wire line_t rd_line_i,
		output logic stall_o,
		output logic wb_empty_o,
		output line_addr_t wb_addr_o,
		output line_t wb_line_o,
		input wire wb_done_i,
		output logic ld_empty_o,
		output logic ld_dup_o,
		output way_t ld_fill_way_o,
		output req_id_t ld_id_o,
		output pci_op_t ld_op_o,
		output line_addr_t ld_addr_o,
		input wire ld_done_i
	);

	localparam int WB_WIDTH = $bits(line_addr_t) + $bits(line_t);
	localparam int LD_WIDTH = 1 + $bits(way_t) + $bits(req_id_t) + $bits(pci_op_t)
		+ $bits(line_addr_t);

	logic wb_offer;
	logic wb_enqueue;
	logic wb_full;
	logic ld_offer;
	logic ld_enqueue;
	logic ld_full;
	logic duplicate;
	line_addr_t victim_addr;
	way_t fill_way;
	logic [LD_WIDTH-1:0] ld_head;
	logic [$bits(pci_op_t)-1:0] ld_op_bits;

	// A dirty line leaves the cache either when a fill evicts it or when it is flushed
	assign wb_offer = rd_valid_i && rd_dirty_i && (rd_op_i == PCI_FLUSH || rd_has_sm_data_i);
	assign ld_offer = rd_valid_i && !rd_hit_i && !rd_has_sm_data_i
		&& rd_op_i != PCI_FLUSH && rd_op_i != PCI_INVALIDATE;

	// Only the writeback queue may push back on the read stage
	assign stall_o = wb_offer && wb_full;
	assign wb_enqueue = wb_offer && !wb_full;
	assign ld_enqueue = ld_offer && !stall_o;

	assign victim_addr = {rd_old_tag_i, rd_addr_i[SET_INDEX_WIDTH-1:0]};

	// A missing line goes into the replacement way, a present one stays where it was found
	assign fill_way = rd_hit_i ? rd_way_i : rd_replace_way_i;

	l2_sync_fifo #(
		.WIDTH(WB_WIDTH),
		.DEPTH(QUEUE_DEPTH)
	) writeback_queue (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.enqueue_i(wb_enqueue),
		.value_i({victim_addr, rd_line_i}),
		.dequeue_i(wb_done_i),
		.full_o(wb_full),
		.empty_o(wb_empty_o),
		.value_o({wb_addr_o, wb_line_o})
	);

	l2_sync_fifo #(
		.WIDTH(LD_WIDTH),
		.DEPTH(QUEUE_DEPTH)
	) load_queue (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.enqueue_i(ld_enqueue),
		.value_i({duplicate, fill_way, rd_id_i, rd_op_i, rd_addr_i}),
		.dequeue_i(ld_done_i),
		.full_o(ld_full),
		.empty_o(ld_empty_o),
		.value_o(ld_head)
	);

	assign {ld_dup_o, ld_fill_way_o, ld_id_o, ld_op_bits, ld_addr_o} = ld_head;
	assign ld_op_o = pci_op_t'(ld_op_bits);

	// The table entry lives until the real fill is handed back, duplicates never own one
	l2_pending_miss #(
		.PENDING_ENTRIES(PENDING_ENTRIES)
	) pending_miss (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.lookup_valid_i(ld_offer),
		.lookup_addr_i(rd_addr_i),
		.alloc_i(ld_enqueue && !duplicate),
		.release_i(ld_done_i && !ld_dup_o),
		.release_addr_i(ld_addr_o),
		.duplicate_o(duplicate)
	);

	// Stalling on a full load queue would deadlock the pipeline, so it must never fill
	assert property (@(posedge clk) disable iff (!arst_n_i) ld_enqueue |-> !ld_full);

endmodule

`default_nettype wire

// ==== hdl/l2_smi_burst.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_smi_burst import l2_smi_pkg::*;
	(
		input wire clk,
		input wire arst_n_i,
		input wire wb_empty_i,
		input wire line_addr_t wb_addr_i,
		input wire line_t wb_line_i,
		output logic wb_done_o,
		input wire ld_empty_i,
		input wire ld_dup_i,
		input wire way_t ld_fill_way_i,
		input wire req_id_t ld_id_i,
		input wire pci_op_t ld_op_i,
		input wire line_addr_t ld_addr_i,
		output logic ld_done_o,
		output logic request_o,
		output logic write_o,
		output mem_addr_t addr_o,
		output word_t data_o,
		input wire ack_i,
		input wire word_t data_i,
		output logic reissue_valid_o,
		output logic reissue_dup_o,
		output way_t reissue_fill_way_o,
		output req_id_t reissue_id_o,
		output pci_op_t reissue_op_o,
		output line_addr_t reissue_addr_o,
		output line_t reissue_line_o
	);

	localparam logic [BEAT_WIDTH-1:0] LAST_BEAT = BEAT_WIDTH'(BURST_BEATS - 1);

	smi_state_t state_q;
	smi_state_t state_d;
	logic [BEAT_WIDTH-1:0] beat_q;
	logic [BEAT_WIDTH-1:0] beat_d;
	word_t load_buf [BURST_BEATS];
	line_addr_t burst_line;

	always_comb
	begin
		state_d = state_q;
		beat_d = beat_q;
		wb_done_o = 1'b0;
		ld_done_o = 1'b0;

		case (state_q)
			STATE_IDLE:
			begin
				// Writebacks go first so that a load never reads a line whose
				// newer copy is still waiting in the writeback queue
				if (!wb_empty_i)
					state_d = STATE_WRITE;
				else if (!ld_empty_i)
					state_d = ld_dup_i ? STATE_ISSUE : STATE_READ;
			end

			STATE_WRITE:
			begin
				if (ack_i)
				begin
					beat_d = beat_q + 1'b1;
					if (beat_q == LAST_BEAT)
					begin
						wb_done_o = 1'b1;
						state_d = STATE_IDLE;
					end
				end
			end

			STATE_READ:
			begin
				if (ack_i)
				begin
					beat_d = beat_q + 1'b1;
					if (beat_q == LAST_BEAT)
						state_d = STATE_ISSUE;
				end
			end

			STATE_ISSUE:
			begin
				ld_done_o = 1'b1;
				state_d = STATE_IDLE;
			end

			default:
				state_d = STATE_IDLE;
		endcase
	end

	// The beat counter wraps back to zero on the last beat of each burst
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= STATE_IDLE;
			beat_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			beat_q <= beat_d;
		end
	end

	always_ff @(posedge clk)
	begin
		if (state_q == STATE_READ && ack_i)
			load_buf[beat_q] <= data_i;
	end

	assign request_o = state_q == STATE_WRITE || state_q == STATE_READ;
	assign write_o = state_q == STATE_WRITE;

	// Beats are word aligned inside the line, so the byte offset is beat * 4
	assign burst_line = write_o ? wb_addr_i : ld_addr_i;
	assign addr_o = {burst_line, beat_q, 2'b00};
	assign data_o = wb_line_i[(BURST_BEATS - 1 - beat_q) * WORD_WIDTH +: WORD_WIDTH];

	always_comb
	begin
		for (int i = 0; i < BURST_BEATS; i++)
			reissue_line_o[(BURST_BEATS - 1 - i) * WORD_WIDTH +: WORD_WIDTH] = load_buf[i];
	end

	// Duplicates carry a stale buffer, the pipeline finds the line already filled
	assign reissue_valid_o = state_q == STATE_ISSUE;
	assign reissue_dup_o = ld_dup_i;
	assign reissue_fill_way_o = ld_fill_way_i;
	assign reissue_id_o = ld_id_i;
	assign reissue_op_o = ld_op_i;
	assign reissue_addr_o = ld_addr_i;

	// A write burst drains the entry at the writeback queue head
	assert property (@(posedge clk) disable iff (!arst_n_i) write_o |-> request_o && !wb_empty_i);

	// A beat the memory has not taken is offered again unchanged
	assert property (@(posedge clk) disable iff (!arst_n_i)
		request_o && !ack_i |=> request_o && $stable(write_o) && $stable(addr_o));

endmodule

`default_nettype wire

// ==== hdl/l2_smi_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_smi_top import l2_smi_pkg::*;
	#(
		parameter int SET_INDEX_WIDTH = 8,
		parameter int QUEUE_DEPTH = 12,
		parameter int PENDING_ENTRIES = 4
	)
	(
		input wire clk,
		input wire arst_n_i,
		input wire rd_valid_i,
		input wire req_id_t rd_id_i,
		input wire pci_op_t rd_op_i,
		input wire way_t rd_way_i,
		input wire line_addr_t rd_addr_i,
		input wire rd_has_sm_data_i,
		input wire rd_hit_i,
		input wire way_t rd_replace_way_i,
		input wire [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] rd_old_tag_i,
		input wire rd_dirty_i,
		input wire line_t rd_line_i,
		output logic stall_o,
		output logic request_o,
		output logic write_o,
		output mem_addr_t addr_o,
		output word_t data_o,
		input wire ack_i,
		input wire word_t data_i,
		output logic reissue_valid_o,
		output logic reissue_dup_o,
		output way_t reissue_fill_way_o,
		output req_id_t reissue_id_o,
		output pci_op_t reissue_op_o,
		output line_addr_t reissue_addr_o,
		output line_t reissue_line_o
	);

	logic wb_empty;
	line_addr_t wb_addr;
	line_t wb_line;
	logic wb_done;
	logic ld_empty;
	logic ld_dup;
	way_t ld_fill_way;
	req_id_t ld_id;
	pci_op_t ld_op;
	line_addr_t ld_addr;
	logic ld_done;

	l2_smi_queue #(
		.SET_INDEX_WIDTH(SET_INDEX_WIDTH),
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.PENDING_ENTRIES(PENDING_ENTRIES)
	) queue_stage (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.rd_valid_i(rd_valid_i),
		.rd_id_i(rd_id_i),
		.rd_op_i(rd_op_i),
		.rd_way_i(rd_way_i),
		.rd_addr_i(rd_addr_i),
		.rd_has_sm_data_i(rd_has_sm_data_i),
		.rd_hit_i(rd_hit_i),
		.rd_replace_way_i(rd_replace_way_i),
		.rd_old_tag_i(rd_old_tag_i),
		.rd_dirty_i(rd_dirty_i),
		.rd_line_i(rd_line_i),
		.stall_o(stall_o),
		.wb_empty_o(wb_empty),
		.wb_addr_o(wb_addr),
		.wb_line_o(wb_line),
		.wb_done_i(wb_done),
		.ld_empty_o(ld_empty),
		.ld_dup_o(ld_dup),
		.ld_fill_way_o(ld_fill_way),
		.ld_id_o(ld_id),
		.ld_op_o(ld_op),
		.ld_addr_o(ld_addr),
		.ld_done_i(ld_done)
	);

	l2_smi_burst burst_stage (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.wb_empty_i(wb_empty),
		.wb_addr_i(wb_addr),
		.wb_line_i(wb_line),
		.wb_done_o(wb_done),
		.ld_empty_i(ld_empty),
		.ld_dup_i(ld_dup),
		.ld_fill_way_i(ld_fill_way),
		.ld_id_i(ld_id),
		.ld_op_i(ld_op),
		.ld_addr_i(ld_addr),
		.ld_done_o(ld_done),
		.request_o(request_o),
		.write_o(write_o),
		.addr_o(addr_o),
		.data_o(data_o),
		.ack_i(ack_i),
		.data_i(data_i),
		.reissue_valid_o(reissue_valid_o),
		.reissue_dup_o(reissue_dup_o),
		.reissue_fill_way_o(reissue_fill_way_o),
		.reissue_id_o(reissue_id_o),
		.reissue_op_o(reissue_op_o),
		.reissue_addr_o(reissue_addr_o),
		.reissue_line_o(reissue_line_o)
	);

endmodule

`default_nettype wire

// ==== test/l2_smi_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_smi_checker import l2_smi_pkg::*;
	#(
		parameter int SET_INDEX_WIDTH = 8,
		parameter int QUEUE_DEPTH = 12
	)
	(
		input wire clk,
		input wire arst_n_i,
		input wire [31:0] cur_test_i,
		input wire [1:0] cur_class_i,
		input wire rd_valid_i,
		input wire pci_op_t rd_op_i,
		input wire req_id_t rd_id_i,
		input wire line_addr_t rd_addr_i,
		input wire way_t rd_replace_way_i,
		input wire [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] rd_old_tag_i,
		input wire line_t rd_line_i,
		input wire stall_o,
		input wire request_o,
		input wire write_o,
		input wire mem_addr_t addr_o,
		input wire word_t data_o,
		input wire ack_i,
		input wire reissue_valid_o,
		input wire reissue_dup_o,
		input wire way_t reissue_fill_way_o,
		input wire req_id_t reissue_id_o,
		input wire pci_op_t reissue_op_o,
		input wire line_addr_t reissue_addr_o,
		input wire line_t reissue_line_o,
		output int error_count_o,
		output int finished_o
	);

	int test_err [256];
	int passed;
	int failed;
	int wb_test_q [$];
	line_addr_t wb_addr_q [$];
	line_t wb_line_q [$];
	int rd_test_q [$];
	line_addr_t rd_addr_q [$];
	int ri_test_q [$];
	logic ri_dup_q [$];
	way_t ri_way_q [$];
	req_id_t ri_id_q [$];
	pci_op_t ri_op_q [$];
	line_addr_t ri_addr_q [$];
	logic in_burst;
	logic burst_write;
	int burst_test;
	int beat;
	line_addr_t burst_addr;
	line_t burst_line;
	int wb_outstanding;
	int wb_lag1;
	int wb_lag2;
	logic stall_seen;
	logic stall_exp;

	// Memory words follow the model's rule of byte address XOR 5a5a5a5a
	function automatic line_t memory_line(input line_addr_t addr);
		line_t l;
		mem_addr_t a;
		for (int i = 0; i < BURST_BEATS; i++)
		begin
			a = {addr, 6'b0} + 32'(i * 4);
			l[(BURST_BEATS - 1 - i) * 32 +: 32] = a ^ 32'h5a5a5a5a;
		end
		return l;
	endfunction

	task automatic mismatch(input int t, input string name, input logic [511:0] got,
		input logic [511:0] exp);
		$display("Fail test %0d %s: got %h expected %h", t, name, got, exp);
		test_err[t]++;
		error_count_o++;
	endtask

	task automatic problem(input string msg);
		$display("Error: %s", msg);
		error_count_o++;
	endtask

	task automatic finish_test(input int t);
		if (test_err[t] == 0)
		begin
			passed++;
			$display("Test %0d passed", t);
		end
		else
		begin
			failed++;
			$display("Test %0d failed with %0d errors", t, test_err[t]);
		end
		finished_o = passed + failed;
	endtask

	initial
	begin
		passed = 0;
		failed = 0;
		error_count_o = 0;
		finished_o = 0;
		in_burst = 1'b0;
		wb_outstanding = 0;
		wb_lag1 = 0;
		wb_lag2 = 0;
		stall_seen = 1'b0;
		for (int i = 0; i < 256; i++)
			test_err[i] = 0;
	end

	always @(negedge clk)
	begin
		if (arst_n_i)
		begin
			// Every writeback not yet past its last beat still occupies the queue
			stall_exp = rd_valid_i && cur_class_i == 2'd3 && wb_outstanding == QUEUE_DEPTH;
			if (stall_o != stall_exp)
				mismatch(cur_test_i, "stall_o", stall_o, stall_exp);
			if (stall_o)
				stall_seen = 1'b1;

			// A burst that begins now was chosen two cycles of queue updates ago
			if (request_o && !in_burst)
			begin
				in_burst = 1'b1;
				burst_write = write_o;
				beat = 0;
				if (write_o)
				begin
					if (wb_test_q.size() == 0)
					begin
						problem("write burst started with no writeback queued");
						burst_test = 0;
					end
					else
					begin
						burst_test = wb_test_q.pop_front();
						burst_addr = wb_addr_q.pop_front();
						burst_line = wb_line_q.pop_front();
					end
				end
				else
				begin
					if (wb_lag2 != 0)
						problem("read burst started while a writeback was still queued");
					if (rd_test_q.size() == 0)
					begin
						problem("read burst started with no load pending");
						burst_test = 0;
					end
					else
					begin
						burst_test = rd_test_q.pop_front();
						burst_addr = rd_addr_q.pop_front();
					end
				end
			end

			if (request_o && ack_i && in_burst)
			begin
				if (write_o != burst_write)
					mismatch(burst_test, "write_o", write_o, burst_write);
				if (addr_o != {burst_addr, 6'b0} + 32'(beat * 4))
					mismatch(burst_test, "addr_o", addr_o, {burst_addr, 6'b0} + 32'(beat * 4));
				if (burst_write && data_o != burst_line[(BURST_BEATS - 1 - beat) * 32 +: 32])
					mismatch(burst_test, "data_o", data_o,
						burst_line[(BURST_BEATS - 1 - beat) * 32 +: 32]);
				beat++;
				if (beat == BURST_BEATS)
				begin
					in_burst = 1'b0;
					if (burst_write)
					begin
						wb_outstanding--;
						finish_test(burst_test);
					end
				end
			end

			if (reissue_valid_o)
			begin
				if (ri_test_q.size() == 0)
					problem("reissue pulse with no load queued");
				else
				begin
					burst_test = ri_test_q.pop_front();
					if (reissue_dup_o != ri_dup_q[0])
						mismatch(burst_test, "reissue_dup_o", reissue_dup_o, ri_dup_q[0]);
					if (reissue_fill_way_o != ri_way_q[0])
						mismatch(burst_test, "reissue_fill_way_o", reissue_fill_way_o, ri_way_q[0]);
					if (reissue_id_o != ri_id_q[0])
						mismatch(burst_test, "reissue_id_o", reissue_id_o, ri_id_q[0]);
					if (reissue_op_o != ri_op_q[0])
						mismatch(burst_test, "reissue_op_o", reissue_op_o, ri_op_q[0]);
					if (reissue_addr_o != ri_addr_q[0])
						mismatch(burst_test, "reissue_addr_o", reissue_addr_o, ri_addr_q[0]);
					if (!ri_dup_q[0] && reissue_line_o != memory_line(ri_addr_q[0]))
						mismatch(burst_test, "reissue_line_o", reissue_line_o,
							memory_line(ri_addr_q[0]));
					void'(ri_dup_q.pop_front());
					void'(ri_way_q.pop_front());
					void'(ri_id_q.pop_front());
					void'(ri_op_q.pop_front());
					void'(ri_addr_q.pop_front());
					finish_test(burst_test);
				end
			end

			wb_lag2 = wb_lag1;

			// Operations accepted at the coming edge
			if (rd_valid_i && !stall_o)
			begin
				case (cur_class_i)
					2'd0:
						finish_test(cur_test_i);
					2'd1, 2'd2:
					begin
						ri_test_q.push_back(cur_test_i);
						ri_dup_q.push_back(cur_class_i == 2'd2);
						ri_way_q.push_back(rd_replace_way_i);
						ri_id_q.push_back(rd_id_i);
						ri_op_q.push_back(rd_op_i);
						ri_addr_q.push_back(rd_addr_i);
						if (cur_class_i == 2'd1)
						begin
							rd_test_q.push_back(cur_test_i);
							rd_addr_q.push_back(rd_addr_i);
						end
					end
					default:
					begin
						wb_test_q.push_back(cur_test_i);
						wb_addr_q.push_back({rd_old_tag_i, rd_addr_i[SET_INDEX_WIDTH-1:0]});
						wb_line_q.push_back(rd_line_i);
						wb_outstanding++;
					end
				endcase
			end

			wb_lag1 = wb_outstanding;
		end
	end

	task automatic report();
		if (!stall_seen)
			problem("stall_o never rose while the writeback queue was full");
		if (in_burst || ri_test_q.size() != 0 || wb_test_q.size() != 0)
			problem("operations were still outstanding at the end of the run");
		$display("Tests passed %0d, failed %0d, errors %0d", passed, failed, error_count_o);
	endtask

endmodule

`default_nettype wire

// ==== test/l2_smi_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module l2_smi_tb import l2_smi_pkg::*;
	();

	localparam int SET_INDEX_WIDTH = 8;
	localparam int QUEUE_DEPTH = 12;
	localparam int MAX_TESTS = 64;

	logic clk;
	logic arst_n_i;
	logic rd_valid_i;
	req_id_t rd_id_i;
	pci_op_t rd_op_i;
	way_t rd_way_i;
	line_addr_t rd_addr_i;
	logic rd_has_sm_data_i;
	logic rd_hit_i;
	way_t rd_replace_way_i;
	logic [LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0] rd_old_tag_i;
	logic rd_dirty_i;
	line_t rd_line_i;
	logic stall_o;
	logic request_o;
	logic write_o;
	mem_addr_t addr_o;
	word_t data_o;
	logic ack_i;
	word_t data_i;
	logic reissue_valid_o;
	logic reissue_dup_o;
	way_t reissue_fill_way_o;
	req_id_t reissue_id_o;
	pci_op_t reissue_op_o;
	line_addr_t reissue_addr_o;
	line_t reissue_line_o;
	logic [31:0] cur_test;
	logic [1:0] cur_class;
	int error_count;
	int finished;
	int num_tests;
	int cycles;
	int cycle_limit;
	int gap;
	int s_test [MAX_TESTS];
	int s_class [MAX_TESTS];
	logic [31:0] s_f [MAX_TESTS][10];

	l2_smi_top #(
		.SET_INDEX_WIDTH(SET_INDEX_WIDTH),
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.PENDING_ENTRIES(4)
	) UUT (
		.clk(clk), .arst_n_i(arst_n_i), .rd_valid_i(rd_valid_i), .rd_id_i(rd_id_i),
		.rd_op_i(rd_op_i), .rd_way_i(rd_way_i), .rd_addr_i(rd_addr_i),
		.rd_has_sm_data_i(rd_has_sm_data_i), .rd_hit_i(rd_hit_i),
		.rd_replace_way_i(rd_replace_way_i), .rd_old_tag_i(rd_old_tag_i),
		.rd_dirty_i(rd_dirty_i), .rd_line_i(rd_line_i), .stall_o(stall_o),
		.request_o(request_o), .write_o(write_o), .addr_o(addr_o), .data_o(data_o),
		.ack_i(ack_i), .data_i(data_i), .reissue_valid_o(reissue_valid_o),
		.reissue_dup_o(reissue_dup_o), .reissue_fill_way_o(reissue_fill_way_o),
		.reissue_id_o(reissue_id_o), .reissue_op_o(reissue_op_o),
		.reissue_addr_o(reissue_addr_o), .reissue_line_o(reissue_line_o)
	);

	l2_smi_checker #(
		.SET_INDEX_WIDTH(SET_INDEX_WIDTH),
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) response_check (
		.clk(clk), .arst_n_i(arst_n_i), .cur_test_i(cur_test), .cur_class_i(cur_class),
		.rd_valid_i(rd_valid_i), .rd_op_i(rd_op_i), .rd_id_i(rd_id_i), .rd_addr_i(rd_addr_i),
		.rd_replace_way_i(rd_replace_way_i), .rd_old_tag_i(rd_old_tag_i),
		.rd_line_i(rd_line_i), .stall_o(stall_o), .request_o(request_o), .write_o(write_o),
		.addr_o(addr_o), .data_o(data_o), .ack_i(ack_i), .reissue_valid_o(reissue_valid_o),
		.reissue_dup_o(reissue_dup_o), .reissue_fill_way_o(reissue_fill_way_o),
		.reissue_id_o(reissue_id_o), .reissue_op_o(reissue_op_o),
		.reissue_addr_o(reissue_addr_o), .reissue_line_o(reissue_line_o),
		.error_count_o(error_count), .finished_o(finished)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Victim line words are spread from one seed per operation
	function automatic line_t victim_line(input logic [31:0] seed);
		line_t l;
		for (int i = 0; i < BURST_BEATS; i++)
			l[(BURST_BEATS - 1 - i) * 32 +: 32] = seed ^ (32'(i) * 32'h11111111);
		return l;
	endfunction

	task automatic load_stimulus();
		int fd;
		int n;
		int t;
		int c;
		reg [8*256-1:0] text;
		fd = $fopen("test/l2_smi_stim.txt", "r");
		num_tests = 0;
		if (fd == 0)
			$display("Error: cannot open test/l2_smi_stim.txt");
		else
		begin
			while (!$feof(fd) && num_tests < MAX_TESTS)
			begin
				text = '0;
				void'($fgets(text, fd));
				n = $sscanf(text, "%d %d %h %h %h %h %h %h %h %h %h %h", t, c,
					s_f[num_tests][0], s_f[num_tests][1], s_f[num_tests][2],
					s_f[num_tests][3], s_f[num_tests][4], s_f[num_tests][5],
					s_f[num_tests][6], s_f[num_tests][7], s_f[num_tests][8],
					s_f[num_tests][9]);
				if (n == 12)
				begin
					s_test[num_tests] = t;
					s_class[num_tests] = c;
					num_tests++;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_operation(input int k);
		cur_test = s_test[k];
		cur_class = s_class[k][1:0];
		rd_valid_i = 1'b1;
		rd_op_i = pci_op_t'(s_f[k][0][2:0]);
		rd_id_i = s_f[k][1][3:0];
		rd_way_i = s_f[k][2][1:0];
		rd_addr_i = s_f[k][3][LINE_ADDR_WIDTH-1:0];
		rd_has_sm_data_i = s_f[k][4][0];
		rd_hit_i = s_f[k][5][0];
		rd_replace_way_i = s_f[k][6][1:0];
		rd_old_tag_i = s_f[k][7][LINE_ADDR_WIDTH-SET_INDEX_WIDTH-1:0];
		rd_dirty_i = s_f[k][8][0];
		rd_line_i = victim_line(s_f[k][9]);
	endtask

	// Memory model with a random gap of 0 to 3 cycles before each acknowledged beat
	always @(posedge clk)
	begin
		#1;
		ack_i = 1'b0;
		if (arst_n_i && request_o)
		begin
			if (gap > 0)
				gap--;
			else
			begin
				ack_i = 1'b1;
				data_i = addr_o ^ 32'h5a5a5a5a;
				gap = $urandom % 4;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles with %0d tests finished", cycles, finished);
			$display("Testbench failed");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(32'hd814));
		arst_n_i = 1'b0;
		rd_valid_i = 1'b0;
		rd_id_i = '0;
		rd_op_i = PCI_LOAD;
		rd_way_i = '0;
		rd_addr_i = '0;
		rd_has_sm_data_i = 1'b0;
		rd_hit_i = 1'b0;
		rd_replace_way_i = '0;
		rd_old_tag_i = '0;
		rd_dirty_i = 1'b0;
		rd_line_i = '0;
		ack_i = 1'b0;
		data_i = '0;
		cur_test = '0;
		cur_class = '0;
		gap = 0;
		cycles = 0;
		cycle_limit = 0;
		load_stimulus();
		cycle_limit = num_tests * 140 + 200;
		repeat (4) @(posedge clk);
		#1 arst_n_i = 1'b1;

		for (int k = 0; k < num_tests; k++)
		begin
			@(posedge clk);
			#1 drive_operation(k);
			@(negedge clk);
			while (stall_o)
				@(negedge clk);
		end
		@(posedge clk);
		#1 rd_valid_i = 1'b0;

		wait (finished == num_tests);
		repeat (4) @(posedge clk);
		response_check.report();
		#1;
		if (error_count == 0 && num_tests > 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== l2_smi_top.f ====
hdl/l2_smi_pkg.sv
hdl/l2_sync_fifo.sv
hdl/l2_pending_miss.sv
hdl/l2_smi_queue.sv
hdl/l2_smi_burst.sv
hdl/l2_smi_top.sv
test/l2_smi_checker.sv
test/l2_smi_tb.sv

// ==== test/l2_smi_stim.txt ====
# test class op id fill_way line_addr has_sm_data hit replace_way old_tag dirty line_seed
# class: 0 none, 1 load, 2 duplicate load, 3 writeback; all but the first two columns in hex
1 1 0 1 0 0000100 0 0 2 00000 0 00000000
2 2 0 2 0 0000100 0 0 3 00000 0 00000000
3 1 0 5 0 0000203 0 0 1 00000 0 00000000
4 0 0 6 1 0000300 0 1 0 00000 0 00000000
5 0 3 7 0 0000301 0 0 0 00000 0 00000000
6 0 2 8 0 0000302 0 1 0 00011 0 00000000
7 3 2 9 1 0000303 0 1 0 00022 1 a5a50001
8 3 1 a 0 0000410 1 0 1 00101 1 11110008
9 3 1 b 0 0000411 1 0 2 00102 1 22220009
10 3 1 c 0 0000412 1 0 3 00103 1 3333000a
11 3 1 d 0 0000413 1 0 0 00104 1 4444000b
12 3 1 e 0 0000414 1 0 1 00105 1 5555000c
13 3 1 f 0 0000415 1 0 2 00106 1 6666000d
14 3 1 0 0 0000416 1 0 3 00107 1 7777000e
15 3 1 1 0 0000417 1 0 0 00108 1 8888000f
16 3 1 2 0 0000418 1 0 1 00109 1 99990010
17 3 1 3 0 0000419 1 0 2 0010a 1 aaaa0011
18 3 1 4 0 000041a 1 0 3 0010b 1 bbbb0012
19 3 1 5 0 000041b 1 0 0 0010c 1 cccc0013
20 3 1 6 0 000041c 1 0 1 0010d 1 dddd0014
21 1 0 c 0 0000500 0 0 2 00000 0 00000000
